/* hdl/obj_pkg.sv */
// Object engine package: table layout, draw command and line buffer types
`default_nettype none

package obj_pkg;

    // Object table layout
    localparam int OBJ_CNT    = 128;                 // Entries in the table
    localparam int OBJ_IDX_W  = $clog2(OBJ_CNT);
    localparam int OBJ_WORDS  = 8;                   // 16-bit words per entry
    localparam int WORD_IDX_W = $clog2(OBJ_WORDS);
    localparam int TBL_AW     = OBJ_IDX_W + WORD_IDX_W;
    localparam int TBL_DEPTH  = OBJ_CNT * OBJ_WORDS;
    localparam logic [WORD_IDX_W-1:0] SCRATCH_IDX = WORD_IDX_W'(7); // Running offset

    // Screen geometry
    localparam logic [8:0] LAST_LINE = 9'd223;       // Also the flip mirror base
    localparam logic [7:0] END_MARK  = 8'hF0;        // Bottom byte at or above ends list

    // Object graphics, 4bpp packed four pixels per ROM word
    localparam int OBJ_WIDTH    = 16;
    localparam int PIX_PER_WORD = 4;
    localparam int ROM_AW       = 18;                // Bank over 15-bit word address

    // Drawer sequence, pixels start once the first word is latched
    localparam int DRAW_CNT_W = 5;
    localparam logic [DRAW_CNT_W-1:0] DRAW_PIX_START = DRAW_CNT_W'(2);
    localparam logic [DRAW_CNT_W-1:0] DRAW_LAST =
        DRAW_CNT_W'(2 + OBJ_WIDTH - 1);

    // Line buffer
    localparam int LBUF_X_W   = 9;
    localparam int LBUF_DEPTH = 1 << LBUF_X_W;

    // Offset word, summed as a number but split by the drawer
    typedef union packed {
        logic [15:0] raw;       // Running value, pitch added here
        struct packed {
            logic        mirror; // Horizontal mirror
            logic [14:0] addr;   // ROM word address
        } f;
    } obj_offset_u;

    typedef struct packed {
        logic [LBUF_X_W-1:0] xpos;
        obj_offset_u         offset;
        logic [2:0]          bank;
        logic [1:0]          prio;
        logic [5:0]          pal;
    } obj_cmd_t;

    typedef struct packed {
        logic [1:0] prio;
        logic [5:0] pal;
        logic [3:0] color;      // Zero is transparent
    } obj_pxl_t;

    typedef struct packed {
        logic                we;
        logic [LBUF_X_W-1:0] x;
        obj_pxl_t            pxl;
    } lbuf_wr_t;

    // CPU request, Wishbone classic
    typedef struct packed {
        logic              cyc;
        logic              stb;
        logic              we;
        logic [TBL_AW-1:0] adr;
        logic [15:0]       dat_w;
    } wb_req_t;

endpackage

`default_nettype wire

/* hdl/obj_table_ram.sv */
// Object table memory, 1024x16 with a Wishbone CPU port and a scanner port
`timescale 1ns/1ps
`default_nettype none

module obj_table_ram (
    input  wire                        clk,
    input  wire                        rst,
    input  wire obj_pkg::wb_req_t      wb_req,
    output logic [15:0]                wb_dat_r,
    output logic                       wb_ack,
    input  wire [obj_pkg::TBL_AW-1:0]  tbl_addr,
    input  wire                        tbl_we,
    input  wire [15:0]                 tbl_din,
    output logic [15:0]                tbl_dout
);

    logic [15:0] mem [obj_pkg::TBL_DEPTH];
    logic        wb_req_vld;

    assign wb_req_vld = wb_req.cyc && wb_req.stb && !wb_ack; // First cycle of request

    // Single ack cycle, dropped while master releases stb
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_req_vld;
        end
    end

    always_ff @(posedge clk) begin
        wb_dat_r <= mem[wb_req.adr];    // Valid together with ack
        if (wb_req_vld && wb_req.we) begin
            mem[wb_req.adr] <= wb_req.dat_w;
        end
        tbl_dout <= mem[tbl_addr];
        if (tbl_we) begin
            mem[tbl_addr] <= tbl_din;   // Scratch write-back only
        end
    end

    // Word 7 belongs to the scanner, no CPU write may collide there
    a_cpu_no_scratch: assert property (@(posedge clk) disable iff (rst)
        (wb_req.cyc && wb_req.stb && wb_req.we)
            |-> wb_req.adr[obj_pkg::WORD_IDX_W-1:0] != obj_pkg::SCRATCH_IDX)
        else $error("CPU write into scratch word at %h", wb_req.adr);

endmodule

`default_nettype wire

/* hdl/obj_scan.sv */
// Object scanner: walks the table per line and issues draw commands
`timescale 1ns/1ps
`default_nettype none

module obj_scan (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        hstart,
    input  wire [8:0]                  vrender,
    input  wire                        flip,
    output logic [obj_pkg::TBL_AW-1:0] tbl_addr,
    output logic                       tbl_we,
    output logic [15:0]                tbl_din,
    input  wire [15:0]                 tbl_dout,
    output logic                       dr_start,
    input  wire                        dr_busy,
    output obj_pkg::obj_cmd_t          dr_cmd,
    output logic                       scan_busy
);

    // One state per table word, data lags the address by one cycle
    enum logic [3:0] {
        ST_IDLE,
        ST_W0,      // Word 0 address out
        ST_TEST,    // Word 0 data, visibility test
        ST_XPOS,
        ST_PITCH,
        ST_BASE,
        ST_ATTR,
        ST_OFFS,    // Scratch data, write-back and issue
        ST_WAIT     // Drawer still busy
    } state;

    logic [obj_pkg::OBJ_IDX_W-1:0]  cur_obj;
    logic [obj_pkg::WORD_IDX_W-1:0] idx;
    logic [7:0]  line;              // Mirrored line being scanned
    logic        first;             // Object starts on this line
    logic [8:0]  xpos;
    logic [15:0] pitch;             // Two's complement, plain add wraps right
    logic [15:0] base;
    logic [5:0]  pal;
    logic [2:0]  bank;
    logic [1:0]  prio;
    logic [8:0]  vrf;
    logic [7:0]  top;
    logic [7:0]  bottom;
    logic        in_zone;
    logic        bad_obj;
    logic        end_mark;
    logic        visible;
    logic        last_obj;
    logic        issue;
    logic        adv;
    logic [15:0] cur_off;

    assign vrf      = flip ? obj_pkg::LAST_LINE - vrender : vrender;
    assign top      = tbl_dout[7:0];
    assign bottom   = tbl_dout[15:8];
    assign in_zone  = line >= top && bottom > line;
    assign bad_obj  = top >= bottom;
    assign end_mark = bottom >= obj_pkg::END_MARK;
    assign visible  = in_zone && !bad_obj;
    assign last_obj = int'(cur_obj) == obj_pkg::OBJ_CNT - 1;

    // Word index follows the state: 0..4 then the scratch word
    always_comb begin
        case (state)
            ST_TEST:  idx = 3'd1;
            ST_XPOS:  idx = 3'd2;
            ST_PITCH: idx = 3'd3;
            ST_BASE:  idx = 3'd4;
            ST_ATTR, ST_OFFS, ST_WAIT: idx = obj_pkg::SCRATCH_IDX;
            default:  idx = 3'd0;
        endcase
    end

    assign tbl_addr = {cur_obj, idx};
    assign cur_off  = first ? base : tbl_dout;   // Base on the top line only
    assign tbl_we   = state == ST_OFFS;
    assign tbl_din  = cur_off + pitch;           // Offset for the next line
    assign issue    = (state == ST_OFFS || state == ST_WAIT) && !dr_busy;
    assign adv      = (state == ST_TEST && !end_mark && !visible) || issue;
    assign scan_busy = state != ST_IDLE || dr_start; // Covers gap before dr_busy

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= ST_IDLE;
            cur_obj  <= '0;
            dr_start <= 1'b0;
        end else begin
            dr_start <= issue;
            case (state)
                ST_IDLE: begin
                    if (hstart && vrf <= obj_pkg::LAST_LINE) begin
                        cur_obj <= '0;
                        state   <= ST_W0;
                    end
                end
                ST_W0:    state <= ST_TEST;
                ST_TEST: begin
                    if (end_mark) begin
                        state <= ST_IDLE;           // End of list
                    end else if (visible) begin
                        state <= ST_XPOS;
                    end
                end
                ST_XPOS:  state <= ST_PITCH;
                ST_PITCH: state <= ST_BASE;
                ST_BASE:  state <= ST_ATTR;
                ST_ATTR:  state <= ST_OFFS;
                ST_OFFS:  if (dr_busy) state <= ST_WAIT;
                default: ;                          // Wait holds the command
            endcase
            // Move to next entry, overrides the case above
            if (adv) begin
                if (last_obj) begin
                    state <= ST_IDLE;
                end else begin
                    cur_obj <= cur_obj + 1'b1;
                    state   <= ST_W0;
                end
            end
        end
    end

    // Object fields and the outgoing command
    always_ff @(posedge clk) begin
        case (state)
            ST_IDLE:  if (hstart) line <= vrf[7:0];
            ST_TEST:  first <= top == line;
            ST_XPOS:  xpos  <= tbl_dout[8:0];
            ST_PITCH: pitch <= tbl_dout;
            ST_BASE:  base  <= tbl_dout;
            ST_ATTR: begin
                pal  <= tbl_dout[13:8];
                bank <= tbl_dout[6:4];
                prio <= tbl_dout[1:0];
            end
            ST_OFFS: begin
                dr_cmd.xpos       <= xpos;
                dr_cmd.offset.raw <= cur_off;       // Drawn offset, before pitch
                dr_cmd.bank       <= bank;
                dr_cmd.prio       <= prio;
                dr_cmd.pal        <= pal;
            end
            default: ;
        endcase
    end

    // Handshake with the drawer, never start on top of a busy drawer
    a_start_idle: assert property (@(posedge clk) disable iff (rst)
        dr_start |-> !dr_busy)
        else $error("dr_start while drawer busy");

endmodule

`default_nettype wire

/* hdl/obj_draw.sv */
// Object drawer: fetches four ROM words and writes 16 pixels to the line buffer
`timescale 1ns/1ps
`default_nettype none

module obj_draw (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        dr_start,
    input  wire obj_pkg::obj_cmd_t     dr_cmd,
    output logic                       dr_busy,
    output logic [obj_pkg::ROM_AW-1:0] rom_addr,
    input  wire [15:0]                 rom_data,
    output obj_pkg::lbuf_wr_t          lbuf_wr
);

    // Count runs 0..17 while busy
    // Word k: address at 4k, data latched at 4k+1, pixels from 4k+2
    logic [obj_pkg::DRAW_CNT_W-1:0] cnt;
    logic        mirror;
    logic [2:0]  bank;
    logic [1:0]  prio;
    logic [5:0]  pal;
    logic [14:0] waddr;             // ROM word now on the bus
    logic [8:0]  x;                 // Wraps at 512
    logic [15:0] sh;                // Nibbles in draw order, MSB out first
    logic        accept;
    logic        pix_en;
    logic        step;
    logic        load;

    assign accept = dr_start && !dr_busy;
    assign pix_en = dr_busy && cnt >= obj_pkg::DRAW_PIX_START;
    assign step   = dr_busy && cnt[1:0] == 2'd0;   // Address consumed
    assign load   = dr_busy && cnt[1:0] == 2'd1;   // ROM data valid

    assign rom_addr = {bank, waddr};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dr_busy <= 1'b0;
            cnt     <= '0;
        end else if (!dr_busy) begin
            if (dr_start) begin
                dr_busy <= 1'b1;
                cnt     <= '0;
            end
        end else begin
            cnt <= cnt + 1'b1;
            if (cnt == obj_pkg::DRAW_LAST) begin
                dr_busy <= 1'b0;            // Last pixel goes out this cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mirror <= dr_cmd.offset.f.mirror;
            waddr  <= dr_cmd.offset.f.addr;
            bank   <= dr_cmd.bank;
            prio   <= dr_cmd.prio;
            pal    <= dr_cmd.pal;
            x      <= dr_cmd.xpos;
        end else begin
            // Mirrored objects walk the ROM backwards
            if (step) begin
                waddr <= mirror ? waddr - 15'd1 : waddr + 15'd1;
            end
            if (load) begin
                // Reverse nibble order so pixels always leave from the top
                sh <= mirror ? {rom_data[3:0], rom_data[7:4],
                                rom_data[11:8], rom_data[15:12]}
                             : rom_data;
            end else if (pix_en) begin
                sh <= {sh[11:0], 4'h0};
            end
            if (pix_en) begin
                x <= x + 9'd1;
            end
        end
    end

    // Only opaque pixels reach the buffer
    always_comb begin
        lbuf_wr.we        = pix_en && sh[15:12] != 4'h0;
        lbuf_wr.x         = x;
        lbuf_wr.pxl.prio  = prio;
        lbuf_wr.pxl.pal   = pal;
        lbuf_wr.pxl.color = sh[15:12];
    end

endmodule

`default_nettype wire

/* hdl/obj_line_buf.sv */
// Ping-pong object line buffer with a draw port and a clear-on-read video port
`timescale 1ns/1ps
`default_nettype none

module obj_line_buf (
    input  wire                          clk,
    input  wire                          rst,
    input  wire                          hstart,
    input  wire obj_pkg::lbuf_wr_t       lbuf_wr,
    input  wire [obj_pkg::LBUF_X_W-1:0]  hdump,
    output obj_pkg::obj_pxl_t            obj_pxl
);

    obj_pkg::obj_pxl_t bank0 [obj_pkg::LBUF_DEPTH];
    obj_pkg::obj_pxl_t bank1 [obj_pkg::LBUF_DEPTH];
    logic              sel;         // Low draws into bank0 and shows bank1

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            sel <= 1'b0;
        end else if (hstart) begin
            sel <= ~sel;            // Swap halves every line
        end
    end

    // Front half read and wiped while the back half takes draws
    always_ff @(posedge clk) begin
        if (sel) begin
            obj_pxl      <= bank0[hdump];
            bank0[hdump] <= '0;
            if (lbuf_wr.we) begin
                bank1[lbuf_wr.x] <= lbuf_wr.pxl;
            end
        end else begin
            obj_pxl      <= bank1[hdump];
            bank1[hdump] <= '0;
            if (lbuf_wr.we) begin
                bank0[lbuf_wr.x] <= lbuf_wr.pxl;
            end
        end
    end

    // Draws finish before the swap and land in the back half of their own line
    a_one_back_write: assert property (@(posedge clk) disable iff (rst)
        lbuf_wr.we |-> !hstart)
        else $error("Line buffer write at swap, x=%0d", lbuf_wr.x);

endmodule

`default_nettype wire

/* hdl/obj_video.sv */
// Object engine top: table, scanner, drawer and line buffer
`timescale 1ns/1ps
`default_nettype none

module obj_video (
    input  wire                          clk,
    input  wire                          rst,
    input  wire obj_pkg::wb_req_t        wb_req,
    output logic [15:0]                  wb_dat_r,
    output logic                         wb_ack,
    output logic [obj_pkg::ROM_AW-1:0]   rom_addr,
    input  wire [15:0]                   rom_data,
    input  wire                          hstart,
    input  wire [8:0]                    vrender,
    input  wire                          flip,
    input  wire [obj_pkg::LBUF_X_W-1:0]  hdump,
    output obj_pkg::obj_pxl_t            obj_pxl,
    output logic                         obj_busy
);

    // Scanner side of the table
    logic [obj_pkg::TBL_AW-1:0] tbl_addr;
    logic                       tbl_we;
    logic [15:0]                tbl_din;
    logic [15:0]                tbl_dout;

    // Scanner to drawer
    logic                       dr_start;
    logic                       dr_busy;
    obj_pkg::obj_cmd_t          dr_cmd;
    logic                       scan_busy;

    obj_pkg::lbuf_wr_t          lbuf_wr;

    assign obj_busy = scan_busy | dr_busy;   // Line done when both settle

    obj_table_ram u_table (
        .clk      (clk),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .tbl_addr (tbl_addr),
        .tbl_we   (tbl_we),
        .tbl_din  (tbl_din),
        .tbl_dout (tbl_dout)
    );

    obj_scan u_scan (
        .clk       (clk),
        .rst       (rst),
        .hstart    (hstart),
        .vrender   (vrender),
        .flip      (flip),
        .tbl_addr  (tbl_addr),
        .tbl_we    (tbl_we),
        .tbl_din   (tbl_din),
        .tbl_dout  (tbl_dout),
        .dr_start  (dr_start),
        .dr_busy   (dr_busy),
        .dr_cmd    (dr_cmd),
        .scan_busy (scan_busy)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .dr_start (dr_start),
        .dr_cmd   (dr_cmd),
        .dr_busy  (dr_busy),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .lbuf_wr  (lbuf_wr)
    );

    obj_line_buf u_lbuf (
        .clk     (clk),
        .rst     (rst),
        .hstart  (hstart),
        .lbuf_wr (lbuf_wr),
        .hdump   (hdump),
        .obj_pxl (obj_pxl)
    );

endmodule

`default_nettype wire

/* sim/tb_obj_video.sv */
// Object engine testbench: Wishbone table loads, ROM model and per-line reference model
`timescale 1ns/1ps
`default_nettype none

module tb_obj_video;

    logic              clk = 1'b0;
    logic              rst = 1'b1;
    obj_pkg::wb_req_t  wb_req = '0;
    logic [15:0]       wb_dat_r;
    logic              wb_ack;
    logic [17:0]       rom_addr;
    logic [15:0]       rom_data = '0;
    logic              hstart = 1'b0;
    logic [8:0]        vrender = 9'd224;        // Off screen, no scan
    logic              flip = 1'b0;
    logic [8:0]        hdump = '0;
    obj_pkg::obj_pxl_t obj_pxl;
    logic              obj_busy;

    logic [15:0]       rom_mem [1 << 18];
    logic [15:0]       shadow [1024];           // CPU image of the table, model keeps word 7
    obj_pkg::obj_pxl_t exp_line [512];
    logic [31:0]       lcg_state = 32'd46;
    int                checks = 0;
    int                errors = 0;
    int                timeouts = 0;
    logic              done = 1'b0;

    always #5 clk = ~clk;

    // Graphics ROM, data one cycle after the address
    always @(posedge clk) begin
        rom_data <= #1 rom_mem[rom_addr];
    end

    obj_video dut_i (
        .clk      (clk),
        .rst      (rst),
        .wb_req   (wb_req),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .rom_addr (rom_addr),
        .rom_data (rom_data),
        .hstart   (hstart),
        .vrender  (vrender),
        .flip     (flip),
        .hdump    (hdump),
        .obj_pxl  (obj_pxl),
        .obj_busy (obj_busy)
    );

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Word 4 layout: pal in 13:8, bank in 6:4, prio in 1:0
    function automatic logic [15:0] attr_word(input logic [5:0] pal, input logic [2:0] bank,
                                              input logic [1:0] prio);
        return {2'b00, pal, 1'b0, bank, 2'b00, prio};
    endfunction

    task automatic step_cycle();
        @(posedge clk);
        #1;                                     // Drive point after the edge
    endtask

    // One classic cycle, held until ack
    task automatic wb_cycle(input logic we, input logic [9:0] adr, input logic [15:0] dat_w,
                            output logic [15:0] dat_r);
        int n;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = dat_w;
        n = 0;
        step_cycle();
        while (!wb_ack && n < 16) begin
            step_cycle();
            n++;
        end
        dat_r  = wb_dat_r;                      // Valid with ack
        wb_req = '0;
        if (!wb_ack) begin
            $display("Timeout: no Wishbone ack for address %h", adr);
            timeouts++;
        end
    endtask

    task automatic wb_write(input logic [9:0] adr, input logic [15:0] dat);
        logic [15:0] ignored;
        wb_cycle(1'b1, adr, dat, ignored);
        shadow[adr] = dat;
    endtask

    task automatic put_obj(input int idx, input logic [7:0] top, input logic [7:0] bottom,
                           input logic [8:0] xpos, input logic [15:0] pitch,
                           input logic [15:0] base, input logic [15:0] attr);
        logic [9:0] a;
        a = 10'(idx * 8);
        wb_write(a, {bottom, top});
        wb_write(a + 10'd1, {7'd0, xpos});
        wb_write(a + 10'd2, pitch);
        wb_write(a + 10'd3, base);
        wb_write(a + 10'd4, attr);
    endtask

    task automatic end_list(input int idx);
        wb_write(10'(idx * 8), {obj_pkg::END_MARK, 8'h00});
    endtask

    task automatic clear_expected();
        int i;
        for (i = 0; i < 512; i++) begin
            exp_line[i] = '0;
        end
    endtask

    // Reference line, walks the shadow table in order, later objects on top
    task automatic build_expected(input logic [8:0] vr, input logic fl);
        logic [8:0]  ln;
        logic [9:0]  a;
        logic [7:0]  top;
        logic [7:0]  bot;
        logic [15:0] off;
        logic [15:0] attr;
        logic [15:0] word;
        logic [14:0] wa;
        logic [3:0]  nib;
        logic [8:0]  x;
        int          i;
        int          k;
        int          n;
        clear_expected();
        ln = fl ? obj_pkg::LAST_LINE - vr : vr;
        if (ln > obj_pkg::LAST_LINE) return;   // Nothing scanned off screen
        for (i = 0; i < 128; i++) begin
            a   = 10'(i * 8);
            top = shadow[a][7:0];
            bot = shadow[a][15:8];
            if (bot >= obj_pkg::END_MARK) break;
            if (top < bot && ln[7:0] >= top && ln[7:0] < bot) begin
                off  = (ln[7:0] == top) ? shadow[a + 10'd3] : shadow[a + 10'd7];
                attr = shadow[a + 10'd4];
                shadow[a + 10'd7] = off + shadow[a + 10'd2];   // Running offset
                for (k = 0; k < 4; k++) begin
                    wa   = off[15] ? off[14:0] - 15'(k) : off[14:0] + 15'(k);
                    word = rom_mem[{attr[6:4], wa}];
                    for (n = 0; n < 4; n++) begin
                        nib = off[15] ? word[4 * n +: 4] : word[12 - 4 * n +: 4];
                        x   = shadow[a + 10'd1][8:0] + 9'(4 * k + n);   // Wraps at 512
                        if (nib != 4'h0) begin
                            exp_line[x] = {attr[1:0], attr[13:8], nib};
                        end
                    end
                end
            end
        end
    endtask

    task automatic pulse_hstart(input logic [8:0] vr);
        vrender = vr;
        hstart  = 1'b1;
        step_cycle();
        hstart  = 1'b0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (obj_busy && n < 5000) begin
            step_cycle();
            n++;
        end
        if (obj_busy) begin
            $display("Timeout: obj_busy still high after %0d cycles", n);
            timeouts++;
        end
    endtask

    // Read out the front half by x, output one cycle behind hdump
    task automatic sweep(input logic check);
        int i;
        for (i = 0; i < 512; i++) begin
            hdump = 9'(i);
            step_cycle();
            if (check) begin
                checks++;
                if (obj_pxl !== exp_line[i]) begin
                    errors++;
                    $display("[ERROR] obj_pxl at x=%h: expected %h, got %h",
                             hdump, exp_line[i], obj_pxl);
                end
            end
        end
    endtask

    task automatic render_line(input logic [8:0] vr, input logic fl);
        flip = fl;
        build_expected(vr, fl);
        pulse_hstart(vr);
        wait_idle();
        pulse_hstart(9'd224);                   // Blank line, swap only
        sweep(1'b1);
    endtask

    task automatic check_scratch(input int idx, input logic [15:0] expv);
        logic [15:0] got;
        wb_cycle(1'b0, 10'(idx * 8 + 7), 16'h0000, got);
        checks++;
        if (got !== expv) begin
            errors++;
            $display("[ERROR] wb_dat_r word 7 of entry %0d: expected %h, got %h",
                     idx, expv, got);
        end
    endtask

    // Three lines of one object, scratch advances by pitch each line
    task automatic test_single_object();
        logic [15:0] base;
        logic [15:0] pitch;
        int          k;
        base  = 16'h0123;
        pitch = 16'h0010;
        put_obj(0, 8'd40, 8'd48, 9'd100, pitch, base, attr_word(6'h15, 3'd2, 2'd1));
        end_list(1);
        for (k = 0; k < 3; k++) begin
            render_line(9'(40 + k), 1'b0);
            check_scratch(0, base + 16'(k + 1) * pitch);
        end
    endtask

    task automatic test_mirror();
        put_obj(0, 8'd80, 8'd90, 9'd200, 16'hFFE0, 16'h8456, attr_word(6'h2A, 3'd5, 2'd3));
        end_list(1);
        render_line(9'd80, 1'b0);
        check_scratch(0, 16'h8436);
        render_line(9'd81, 1'b0);
        check_scratch(0, 16'h8416);             // Negative pitch keeps the mirror bit
    endtask

    task automatic test_visibility();
        put_obj(0, 8'd60, 8'd64, 9'd300, 16'h0008, 16'h2000, attr_word(6'h01, 3'd0, 2'd0));
        put_obj(1, 8'd10, 8'd20, 9'd300, 16'h0001, 16'h2100, attr_word(6'h02, 3'd1, 2'd1));
        put_obj(2, 8'd60, 8'd60, 9'd302, 16'h0001, 16'h2200, attr_word(6'h03, 3'd2, 2'd2));
        put_obj(3, 8'd60, 8'd62, 9'd308, 16'h0001, 16'h2300, attr_word(6'h3F, 3'd3, 2'd2));
        put_obj(4, 8'd60, 8'd61, 9'd505, 16'h0001, 16'h2400, attr_word(6'h10, 3'd4, 2'd1));
        end_list(5);
        put_obj(6, 8'd60, 8'd70, 9'd400, 16'h0001, 16'h2600, attr_word(6'h20, 3'd6, 2'd3));
        render_line(9'd60, 1'b0);
    endtask

    // Mirrored line 223-123 = 100, then a second pass over wiped entries
    task automatic test_flip();
        put_obj(0, 8'd100, 8'd104, 9'd32, 16'h0004, 16'h1000, attr_word(6'h07, 3'd1, 2'd2));
        end_list(1);
        render_line(9'd123, 1'b1);
        clear_expected();
        sweep(1'b1);
        flip = 1'b0;
    endtask

    initial begin : main
        int          a;
        logic [31:0] r;
        for (a = 0; a < 1024; a++) begin
            shadow[a] = '0;
        end
        for (a = 0; a < (1 << 18); a++) begin
            r = next_rand();
            rom_mem[a] = r[31:16] & r[23:8];    // AND leaves plenty of clear nibbles
        end
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        step_cycle();
        // Both halves power up unknown, read them clean
        sweep(1'b0);
        pulse_hstart(9'd224);
        sweep(1'b0);
        test_single_object();
        test_mirror();
        test_visibility();
        test_flip();
        done = 1'b1;
    end

    // Run limit and final verdict
    initial begin : report
        int n;
        n = 0;
        while (!done && timeouts == 0 && n < 200000) begin
            @(posedge clk);
            n++;
        end
        if (!done && timeouts == 0) begin
            $display("Run did not complete within %0d cycles", n);
        end
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (done && timeouts == 0 && errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* list.f */
hdl/obj_pkg.sv
hdl/obj_table_ram.sv
hdl/obj_scan.sv
hdl/obj_draw.sv
hdl/obj_line_buf.sv
hdl/obj_video.sv
sim/tb_obj_video.sv

/* Makefile */
# Object engine simulation with Verilator

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, pass if the pass message appears"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f list.f --top-module tb_obj_video -o sim_obj
	@out=$$(./obj_dir/sim_obj); echo "$$out"; echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf obj_dir
